// ==== cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Request path configuration

// Number of request FIFO entries
// Also the credit count the producer starts with
// Must be at least 2
`define CACHE_FIFO_DEPTH 4

// Width of the rolling request tag
// Tags wrap, so memory sees 2**CACHE_TAG_W distinct values
`define CACHE_TAG_W 4

// Byte address width on core and memory side
`define CACHE_ADDR_W 32

`endif

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    // Basic field types
    typedef logic [`CACHE_ADDR_W-1:0] cache_addr_t;
    typedef logic [31:0]              cache_data_t;
    // One enable bit per byte lane of the data word
    typedef logic [3:0]               cache_be_t;
    typedef logic [`CACHE_TAG_W-1:0]  cache_tag_t;

    // Access size
    // Encoding 2'b11 is not legal
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } cache_size_e;

    // Write request as issued by the core
    // Byte address, must be naturally aligned to size
    typedef struct packed {
        cache_addr_t addr;
        cache_data_t wdata;
        cache_size_e size;
    } core_req_t;

    // Write request as stored in the FIFO and sent to memory
    // addr has its two low bits cleared
    // wdata is passed through unshifted
    // be selects the written byte lanes
    // tag is the per-request sequence number
    typedef struct packed {
        cache_addr_t addr;
        cache_data_t wdata;
        cache_be_t   be;
        cache_tag_t  tag;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== cache_fifo_reg.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_fifo_reg #(
    parameter int unsigned FIFO_DEPTH = 2,
    parameter type         fifo_data_t = logic
) (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire logic       w_i,
    output logic            wok_o,
    input  wire fifo_data_t wdata_i,
    input  wire logic       r_i,
    output logic            rok_o,
    output fifo_data_t      rdata_o
);

    // Pointer type, depth is at least 2 so width is at least 1
    typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

    localparam ptr_t PTR_MAX = ptr_t'(FIFO_DEPTH - 1);

    // Storage, no reset needed
    fifo_data_t mem_q [FIFO_DEPTH];

    ptr_t rptr_q, rptr_d;
    ptr_t wptr_q, wptr_d;
    // Set when the write pointer wrapped and the read pointer has not yet
    logic cross_q, cross_d;
    logic ptr_eq;
    logic empty, full;
    logic rexec, wexec;

    // Depth 1 would need a separate single-entry buffer
    if (FIFO_DEPTH < 2) begin : gen_depth_check
        $error("cache_fifo_reg: FIFO_DEPTH must be at least 2");
    end

    // Equal pointers mean full or empty, the crossover flag decides
    assign ptr_eq = (rptr_q == wptr_q);
    assign empty  = ptr_eq && !cross_q;
    assign full   = ptr_eq &&  cross_q;

    assign wok_o = !full;
    assign rok_o = !empty;

    // Guarded requests
    assign wexec = w_i && !full;
    assign rexec = r_i && !empty;

    // Next pointer and crossover state
    always_comb begin
        rptr_d  = rptr_q;
        wptr_d  = wptr_q;
        cross_d = cross_q;

        if (rexec) begin
            rptr_d = (rptr_q == PTR_MAX) ? '0 : rptr_q + 1'b1;
        end
        if (wexec) begin
            wptr_d = (wptr_q == PTR_MAX) ? '0 : wptr_q + 1'b1;
        end

        // Write wrap sets, read wrap clears
        // Both cannot wrap in one cycle unless pointers were apart by a full turn
        if (wexec && (wptr_q == PTR_MAX)) begin
            cross_d = 1'b1;
        end else if (rexec && (rptr_q == PTR_MAX)) begin
            cross_d = 1'b0;
        end
    end

    // Storage write
    always_ff @(posedge clk_i) begin
        if (wexec) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

    // Head of queue, valid only while rok_o is high
    assign rdata_o = mem_q[rptr_q];

    // Control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rptr_q  <= '0;
            wptr_q  <= '0;
            cross_q <= 1'b0;
        end else begin
            rptr_q  <= rptr_d;
            wptr_q  <= wptr_d;
            cross_q <= cross_d;
        end
    end

    // Upstream credit scheme must never overrun the FIFO
    no_write_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_i |-> !full)
        else $error("cache_fifo_reg: write while full");

    // Consumer only pops on rok
    no_read_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_i |-> !empty)
        else $error("cache_fifo_reg: read while empty");

    // Read pointer never passes the write pointer
    ptr_order_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!cross_q && (rptr_q <= wptr_q)) || (cross_q && (rptr_q >= wptr_q)))
        else $error("cache_fifo_reg: read pointer ahead of write pointer");

endmodule

`default_nettype wire

// ==== cache_req_producer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_req_producer (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 core_valid_i,
    input  wire cache_pkg::core_req_t core_req_i,
    input  wire logic                 credit_ret_i,
    output logic                      core_ready_o,
    output logic                      push_o,
    output cache_pkg::mem_req_t       push_req_o
);
    import cache_pkg::*;

    // Counter must hold 0 up to the full depth
    localparam int unsigned CREDIT_W = $clog2(`CACHE_FIFO_DEPTH + 1);

    logic [CREDIT_W-1:0] credit_q, credit_d;
    cache_tag_t          tag_q;
    // Byte lanes for an access at offset 0
    cache_be_t           be_base;

    // Accept while any FIFO slot is owed to us
    assign core_ready_o = (credit_q != '0);
    assign push_o       = core_valid_i && core_ready_o;

    // Unshifted mask, one bit per byte of the access
    always_comb begin
        unique case (core_req_i.size)
            SIZE_BYTE: be_base = 4'b0001;
            SIZE_HALF: be_base = 4'b0011;
            SIZE_WORD: be_base = 4'b1111;
            default:   be_base = 4'b0000;
        endcase
    end

    // Memory request
    // Word address plus lane mask shifted to the byte offset
    assign push_req_o.addr  = {core_req_i.addr[`CACHE_ADDR_W-1:2], 2'b00};
    assign push_req_o.wdata = core_req_i.wdata;
    assign push_req_o.be    = be_base << core_req_i.addr[1:0];
    assign push_req_o.tag   = tag_q;

    // Credit count, push and return in one cycle cancel out
    always_comb begin
        credit_d = credit_q;
        if (push_o && !credit_ret_i) begin
            credit_d = credit_q - 1'b1;
        end else if (!push_o && credit_ret_i) begin
            credit_d = credit_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q <= CREDIT_W'(`CACHE_FIFO_DEPTH);
            tag_q    <= '0;
        end else begin
            credit_q <= credit_d;
            // Tag wraps naturally
            if (push_o) begin
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    // Natural alignment of accepted requests
    aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_o |-> ((core_req_i.size == SIZE_BYTE) ||
                    ((core_req_i.size == SIZE_HALF) && !core_req_i.addr[0]) ||
                    ((core_req_i.size == SIZE_WORD) && (core_req_i.addr[1:0] == 2'b00))))
        else $error("cache_req_producer: misaligned or illegal request");

    // Consumer returns at most what was pushed
    credit_max_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_q <= CREDIT_W'(`CACHE_FIFO_DEPTH))
        else $error("cache_req_producer: credit count above FIFO depth");

endmodule

`default_nettype wire

// ==== cache_req_consumer.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_req_consumer (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire logic                rok_i,
    input  wire cache_pkg::mem_req_t rdata_i,
    input  wire logic                mem_ready_i,
    output logic                     pop_o,
    output logic                     credit_ret_o,
    output logic                     mem_valid_o,
    output cache_pkg::mem_req_t      mem_req_o
);
    import cache_pkg::*;

    // Output register
    mem_req_t req_q;
    logic     valid_q;
    // Register leaves this cycle
    logic     drain;

    assign drain = valid_q && mem_ready_i;

    // Refill when empty or when the current request is taken
    assign pop_o = rok_i && (!valid_q || drain);

    // Each pop frees one FIFO slot
    assign credit_ret_o = pop_o;

    assign mem_valid_o = valid_q;
    assign mem_req_o   = req_q;

    // Valid bit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (pop_o) begin
            valid_q <= 1'b1;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    // Payload only moves on a pop, so it holds under stall
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            req_q <= rdata_i;
        end
    end

    // Stalled request stays put until memory takes it
    stall_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_valid_o && !mem_ready_i) |=> (mem_valid_o && $stable(mem_req_o)))
        else $error("cache_req_consumer: memory request changed while stalled");

endmodule

`default_nettype wire

// ==== cache_req_path.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_cfg.svh"

module cache_req_path (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 core_valid_i,
    input  wire cache_pkg::core_req_t core_req_i,
    output logic                      core_ready_o,
    output logic                      mem_valid_o,
    output cache_pkg::mem_req_t       mem_req_o,
    input  wire logic                 mem_ready_i
);
    import cache_pkg::*;

    // Producer to FIFO
    logic     push;
    mem_req_t push_req;
    // FIFO to consumer
    logic     rok;
    mem_req_t rdata;
    logic     pop;
    // Consumer back to producer
    logic     credit_ret;

    cache_req_producer cache_req_producer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .core_valid_i (core_valid_i),
        .core_req_i   (core_req_i),
        .credit_ret_i (credit_ret),
        .core_ready_o (core_ready_o),
        .push_o       (push),
        .push_req_o   (push_req)
    );

    // Write-ok left open, credits already keep the FIFO from overflowing
    cache_fifo_reg #(
        .FIFO_DEPTH  (`CACHE_FIFO_DEPTH),
        .fifo_data_t (mem_req_t)
    ) cache_fifo_reg_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (push),
        .wok_o   (),
        .wdata_i (push_req),
        .r_i     (pop),
        .rok_o   (rok),
        .rdata_o (rdata)
    );

    cache_req_consumer cache_req_consumer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rok_i        (rok),
        .rdata_i      (rdata),
        .mem_ready_i  (mem_ready_i),
        .pop_o        (pop),
        .credit_ret_o (credit_ret),
        .mem_valid_o  (mem_valid_o),
        .mem_req_o    (mem_req_o)
    );

endmodule

`default_nettype wire

// ==== tb_cache_req_path.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_cfg.svh"

module tb_cache_req_path;
    import cache_pkg::*;

    localparam int unsigned TABLE_LEN      = 16;
    localparam int unsigned DEPTH          = `CACHE_FIFO_DEPTH;
    localparam int unsigned TIMEOUT_CYCLES = TABLE_LEN * 40 + 200;

    // One stimulus row with its hand-computed memory view
    typedef struct packed {
        cache_addr_t addr;
        cache_size_e size;
        cache_data_t wdata;
        cache_be_t   exp_be;
        cache_addr_t exp_addr;
    } table_entry_t;

    // DUT connections
    logic      clk;
    logic      rst_n;
    logic      core_valid;
    core_req_t core_req;
    logic      core_ready;
    logic      mem_valid;
    mem_req_t  mem_req;
    logic      mem_ready;

    table_entry_t stim_table [TABLE_LEN];

    // Expected requests in acceptance order
    mem_req_t   exp_q [$];
    mem_req_t   cur_exp;
    mem_req_t   exp_req;
    mem_req_t   held_req;
    cache_tag_t exp_tag;
    logic       stalled;

    // 0 holds memory off, 1 always ready, 2 random
    int unsigned ready_mode;
    int          seed;
    int unsigned err_cnt;
    int unsigned accept_cnt;
    int unsigned deliver_cnt;

    cache_req_path cache_req_path_i (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .core_valid_i (core_valid),
        .core_req_i   (core_req),
        .core_ready_o (core_ready),
        .mem_valid_o  (mem_valid),
        .mem_req_o    (mem_req),
        .mem_ready_i  (mem_ready)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic set_entry(input int unsigned idx, input cache_addr_t addr,
                             input cache_size_e size, input cache_data_t wdata,
                             input cache_be_t be, input cache_addr_t exp_addr);
        stim_table[idx] = '{addr, size, wdata, be, exp_addr};
    endtask

    // Byte lanes worked out by hand from size and offset
    task automatic load_table();
        set_entry(0,  32'h0000_1000, SIZE_BYTE, 32'h0000_00a1, 4'b0001, 32'h0000_1000);
        set_entry(1,  32'h0000_1001, SIZE_BYTE, 32'h0000_b200, 4'b0010, 32'h0000_1000);
        set_entry(2,  32'h0000_1002, SIZE_BYTE, 32'h00c3_0000, 4'b0100, 32'h0000_1000);
        set_entry(3,  32'h0000_1003, SIZE_BYTE, 32'hd400_0000, 4'b1000, 32'h0000_1000);
        set_entry(4,  32'h0000_2000, SIZE_HALF, 32'h0000_5a5a, 4'b0011, 32'h0000_2000);
        set_entry(5,  32'h0000_2002, SIZE_HALF, 32'h1234_0000, 4'b1100, 32'h0000_2000);
        set_entry(6,  32'h0000_3004, SIZE_WORD, 32'hdead_beef, 4'b1111, 32'h0000_3004);
        set_entry(7,  32'h8000_0007, SIZE_BYTE, 32'h7700_0000, 4'b1000, 32'h8000_0004);
        set_entry(8,  32'h8000_0006, SIZE_HALF, 32'hcafe_0000, 4'b1100, 32'h8000_0004);
        set_entry(9,  32'hffff_fffc, SIZE_WORD, 32'h0123_4567, 4'b1111, 32'hffff_fffc);
        set_entry(10, 32'h0000_0005, SIZE_BYTE, 32'h0000_3c00, 4'b0010, 32'h0000_0004);
        set_entry(11, 32'h0000_000a, SIZE_BYTE, 32'h0099_0000, 4'b0100, 32'h0000_0008);
        set_entry(12, 32'h0000_000c, SIZE_HALF, 32'h0000_f00d, 4'b0011, 32'h0000_000c);
        set_entry(13, 32'h1234_567a, SIZE_HALF, 32'hbeef_0000, 4'b1100, 32'h1234_5678);
        set_entry(14, 32'h1234_5679, SIZE_BYTE, 32'h0000_e100, 4'b0010, 32'h1234_5678);
        set_entry(15, 32'h0000_0010, SIZE_WORD, 32'h8badf00d, 4'b1111, 32'h0000_0010);
    endtask

    // Present one row and hold it until the producer takes it
    task automatic send_req(input int unsigned idx);
        table_entry_t e;
        e = stim_table[idx % TABLE_LEN];
        @(negedge clk);
        core_valid    = 1'b1;
        core_req      = '{e.addr, e.wdata, e.size};
        cur_exp.addr  = e.exp_addr;
        cur_exp.wdata = e.wdata;
        cur_exp.be    = e.exp_be;
        cur_exp.tag   = '0;
        do begin
            @(posedge clk);
        end while (!core_ready);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
    endtask

    // Memory ready driven on the falling edge
    initial begin
        forever begin
            @(negedge clk);
            case (ready_mode)
                0:       mem_ready = 1'b0;
                1:       mem_ready = 1'b1;
                default: mem_ready = (($random(seed) & 3) != 0);
            endcase
        end
    end

    // Scoreboard for both handshakes
    always @(posedge clk) begin
        if (rst_n) begin
            // Tag model counts every accepted request
            if (core_valid && core_ready) begin
                exp_req     = cur_exp;
                exp_req.tag = exp_tag;
                exp_q.push_back(exp_req);
                exp_tag     = exp_tag + 1'b1;
                accept_cnt++;
            end
            // Stalled request must not move
            if (stalled) begin
                assert (mem_valid && (mem_req === held_req)) else begin
                    err_cnt++;
                    $display("MISMATCH at %0t: stalled request changed, valid %b req %h was %h",
                             $time, mem_valid, mem_req, held_req);
                end
            end
            if (mem_valid && mem_ready) begin
                assert (exp_q.size() != 0) else begin
                    err_cnt++;
                    $display("ERROR at %0t: memory got a request nobody sent", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_req = exp_q.pop_front();
                    deliver_cnt++;
                    assert (mem_req === exp_req) else begin
                        err_cnt++;
                        $display("MISMATCH at %0t: got addr %h be %b wdata %h tag %0d",
                                 $time, mem_req.addr, mem_req.be, mem_req.wdata, mem_req.tag);
                        $display("  expected addr %h be %b wdata %h tag %0d",
                                 exp_req.addr, exp_req.be, exp_req.wdata, exp_req.tag);
                    end
                end
            end
            stalled  = mem_valid && !mem_ready;
            held_req = mem_req;
        end
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d clock cycles, the requests never finished draining",
                 TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int unsigned gap;
        seed        = 32'hba56eec0;
        rst_n       = 1'b0;
        core_valid  = 1'b0;
        core_req    = '0;
        mem_ready   = 1'b0;
        ready_mode  = 0;
        cur_exp     = '0;
        exp_tag     = '0;
        stalled     = 1'b0;
        held_req    = '0;
        err_cnt     = 0;
        accept_cnt  = 0;
        deliver_cnt = 0;
        load_table();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle state right after reset
        @(posedge clk);
        assert (!mem_valid && core_ready) else begin
            err_cnt++;
            $display("MISMATCH at %0t: after reset mem_valid %b core_ready %b",
                     $time, mem_valid, core_ready);
        end

        // Memory held off while the FIFO and output register fill
        for (int unsigned i = 0; i < DEPTH + 1; i++) begin
            send_req(i);
        end
        @(negedge clk);
        core_req = '{stim_table[DEPTH + 1].addr, stim_table[DEPTH + 1].wdata,
                     stim_table[DEPTH + 1].size};
        repeat (12) begin
            @(posedge clk);
            assert (!core_ready) else begin
                err_cnt++;
                $display("MISMATCH at %0t: core_ready high with all credits spent", $time);
            end
        end
        assert (accept_cnt == DEPTH + 1) else begin
            err_cnt++;
            $display("MISMATCH at %0t: %0d requests accepted under back-pressure, expected %0d",
                     $time, accept_cnt, DEPTH + 1);
        end
        ready_mode = 1;
        @(negedge clk);
        core_valid = 1'b0;
        wait_drained();

        // Random memory stalls and core gaps
        ready_mode = 2;
        for (int unsigned i = 0; i < TABLE_LEN; i++) begin
            gap = $random(seed) & 3;
            if (gap != 0) begin
                @(negedge clk);
                core_valid = 1'b0;
                repeat (gap - 1) @(negedge clk);
            end
            send_req(i);
        end
        ready_mode = 1;
        @(negedge clk);
        core_valid = 1'b0;
        wait_drained();

        // Each request went out exactly once
        assert (deliver_cnt == accept_cnt && accept_cnt == DEPTH + 1 + TABLE_LEN) else begin
            err_cnt++;
            $display("MISMATCH at %0t: %0d requests accepted and %0d delivered",
                     $time, accept_cnt, deliver_cnt);
            $display("  expected %0d of each", DEPTH + 1 + TABLE_LEN);
        end

        $display("Errors: %0d, accepted: %0d, delivered: %0d",
                 err_cnt, accept_cnt, deliver_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
cache_pkg.sv
cache_fifo_reg.sv
cache_req_producer.sv
cache_req_consumer.sv
cache_req_path.sv
tb_cache_req_path.sv
